//--- Makefile
VERILATOR  ?= verilator
FILELIST   ?= project.f
TOP_TB     ?= cfgTopTb
TOP_RTL    ?= cfgTop
BUILD_DIR  ?= build
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert -j 0
PASS_MSG   ?= Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP_RTL) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP_TB) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP_TB)
	./$(BUILD_DIR)/V$(TOP_TB) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- logic/cfgApbSlave.sv
`timescale 1ns/1ps
`default_nettype none

`include "cfgDefs_defs.svh"

module cfgApbSlave
  import cfgPkg::*;
(
  input  wire logic                       clk,
  input  wire logic                       rstN,
  input  wire logic                       psel,
  input  wire logic                       penable,
  input  wire logic                       pwrite,
  input  wire logic [`CFG_ADDR_W-1:0]     paddr,
  input  wire confWordT                   pwdata,
  output confWordT                        prdata,
  output logic                            pready,
  output logic                            pslverr,
  input  wire confWordT [`CFG_NREG-1:0]   regResetVals,
  output confWordT [`CFG_NREG-1:0]        regBank,
  output logic                            chunkValid,
  output confWordT                        chunkData,
  input  wire logic                       chunkReady
);

  localparam logic [`CFG_ADDR_W-1:0] ProgAddr = `CFG_PROG_ADDR;
  localparam int IdxW = $clog2(`CFG_NREG);

  apbStateT state;
  apbStateT nextState;
  regIdxT   regIdx;
  logic     regHit;
  logic     progHit;
  logic     access;
  logic     wrReg;

  ////////////////////////////////////////////////////////////////////////////
  // address decode
  ////////////////////////////////////////////////////////////////////////////

  // registers sit word aligned below the program port
  assign regHit  = paddr < ProgAddr;
  assign progHit = paddr == ProgAddr;
  assign regIdx  = paddr[IdxW+1:2];

  always_comb begin
    nextState = state;
    case (state)
      IDLE:   if (psel && !penable) nextState = ACCESS;
      ACCESS: if (!psel || pready) nextState = IDLE;
      default: nextState = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= IDLE;
    end else begin
      state <= nextState;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // access phase
  ////////////////////////////////////////////////////////////////////////////

  assign access = (state == ACCESS) && psel && penable;

  // only program writes wait for the deserializer
  assign pready  = access && !(progHit && pwrite && !chunkReady);
  assign pslverr = access && !regHit && !progHit;

  assign wrReg      = access && pwrite && regHit;
  assign chunkValid = access && pwrite && progHit;
  assign chunkData  = pwdata;

  // out of range and program port read back as zero
  assign prdata = (access && !pwrite && regHit) ? regBank[regIdx] : '0;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      regBank <= regResetVals;
    end else if (wrReg) begin
      regBank[regIdx] <= pwdata;
    end
  end

endmodule

`default_nettype wire

//--- logic/cfgDefs_defs.svh
`ifndef CFG_DEFS_SVH
`define CFG_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// configuration bus
////////////////////////////////////////////////////////////////////////////

`define CFG_NCONF 16
`define CFG_NREG 32
`define CFG_ADDR_W 8
`define CFG_PROG_ADDR 8'h80

////////////////////////////////////////////////////////////////////////////
// field widths
////////////////////////////////////////////////////////////////////////////

// spike filter
`define SF_FILTS 10
`define SF_STATE 27

// spike generator, four generators
`define SG_GENS 4
`define SG_PERIOD 16
`define SG_TAG 11

// time manager
`define TM_TIME 48
`define TM_UNIT 16

// program word is genIdx, period, ticks, tag
`define CFG_PROG_W 47
`define CFG_PROG_CHUNKS 3

////////////////////////////////////////////////////////////////////////////
// register indices, multi-word fields stored low word first
////////////////////////////////////////////////////////////////////////////

`define CFG_REG_FILTS_USED 0
`define CFG_REG_INC_CONST 1
`define CFG_REG_DECAY_CONST 3
`define CFG_REG_GENS_USED 5
`define CFG_REG_GENS_EN 6
`define CFG_REG_UNIT_LEN 7
`define CFG_REG_TIME_ELAPSED 8
`define CFG_REG_HB_EVERY 11
`define CFG_REG_RESET_TIME 14
`define CFG_REG_REPORT_TAGS 15
`define CFG_REG_BD_RESET 16

`endif

//--- logic/cfgMapper.sv
`timescale 1ns/1ps
`default_nettype none

`include "cfgDefs_defs.svh"

module cfgMapper
  import cfgPkg::*;
(
  input  wire logic                       clk,
  input  wire logic                       rstN,
  input  wire confWordT [`CFG_NREG-1:0]   regBank,
  output confWordT [`CFG_NREG-1:0]        regResetVals,
  output logic [`SF_FILTS-1:0]            filtsUsed,
  output logic [`SF_STATE-1:0]            incrementConstant,
  output logic [`SF_STATE-1:0]            decayConstant,
  output logic [`SG_GENS-1:0]             gensUsed,
  output logic [`SG_GENS-1:0]             gensEn,
  output unitLenT                         unitLen,
  output timeT                            timeElapsed,
  output timeT                            sendHbEvery,
  output logic                            resetTime,
  output logic                            reportTags,
  output logic                            pReset,
  output logic                            sReset,
  input  wire logic                       chunkValid,
  input  wire confWordT                   chunkData,
  output logic                            chunkReady,
  output logic                            progValid,
  input  wire logic                       progReady,
  output logic [`SG_GENS-1:0]             progGenIdx,
  output logic [`SG_PERIOD-1:0]           progPeriod,
  output logic [`SG_PERIOD-1:0]           progTicks,
  output logic [`SG_TAG-1:0]              progTag
);

  ////////////////////////////////////////////////////////////////////////////
  // bit offsets of each field in the flat bank
  ////////////////////////////////////////////////////////////////////////////

  localparam int WordW        = `CFG_NCONF;
  localparam int FiltsLsb     = `CFG_REG_FILTS_USED * WordW;
  localparam int IncLsb       = `CFG_REG_INC_CONST * WordW;
  localparam int DecayLsb     = `CFG_REG_DECAY_CONST * WordW;
  localparam int GensUsedLsb  = `CFG_REG_GENS_USED * WordW;
  localparam int GensEnLsb    = `CFG_REG_GENS_EN * WordW;
  localparam int UnitLenLsb   = `CFG_REG_UNIT_LEN * WordW;
  localparam int ElapsedLsb   = `CFG_REG_TIME_ELAPSED * WordW;
  localparam int HbEveryLsb   = `CFG_REG_HB_EVERY * WordW;
  localparam int ResetTimeLsb = `CFG_REG_RESET_TIME * WordW;
  localparam int TagsLsb      = `CFG_REG_REPORT_TAGS * WordW;
  localparam int BdResetLsb   = `CFG_REG_BD_RESET * WordW;

  logic [`CFG_NREG*WordW-1:0] bankFlat;
  logic [`CFG_NREG*WordW-1:0] resetFlat;
  progWordT                   progWord;

  // low word first, so a flat view lines fields up directly
  assign bankFlat = regBank;

  assign filtsUsed         = bankFlat[FiltsLsb +: `SF_FILTS];
  assign incrementConstant = bankFlat[IncLsb +: `SF_STATE];
  assign decayConstant     = bankFlat[DecayLsb +: `SF_STATE];
  assign gensUsed          = bankFlat[GensUsedLsb +: `SG_GENS];
  assign gensEn            = bankFlat[GensEnLsb +: `SG_GENS];
  assign unitLen           = bankFlat[UnitLenLsb +: `TM_UNIT];
  assign timeElapsed       = bankFlat[ElapsedLsb +: `TM_TIME];
  assign sendHbEvery       = bankFlat[HbEveryLsb +: `TM_TIME];
  assign resetTime         = bankFlat[ResetTimeLsb];
  assign reportTags        = bankFlat[TagsLsb];
  assign pReset            = bankFlat[BdResetLsb];
  assign sReset            = bankFlat[BdResetLsb + 1];

  ////////////////////////////////////////////////////////////////////////////
  // reset values, unlisted and reserved words stay zero
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    resetFlat = '0;
    resetFlat[IncLsb +: `SF_STATE]     = `SF_STATE'(1);
    // 10000 clocks per unit, heartbeat every 10000 units
    resetFlat[UnitLenLsb +: `TM_UNIT]  = `TM_UNIT'(10000);
    resetFlat[HbEveryLsb +: `TM_TIME]  = `TM_TIME'(10000);
    resetFlat[TagsLsb]                 = 1'b1;
    // chip held in reset until the host releases it
    resetFlat[BdResetLsb +: 2]         = 2'b11;
  end

  assign regResetVals = resetFlat;

  ////////////////////////////////////////////////////////////////////////////
  // program word assembly
  ////////////////////////////////////////////////////////////////////////////

  progDeserializer #(
    .outW    (`CFG_PROG_W),
    .nChunks (`CFG_PROG_CHUNKS)
  ) u_progDes (
    .clk      (clk),
    .rstN     (rstN),
    .inValid  (chunkValid),
    .inData   (chunkData),
    .inReady  (chunkReady),
    .outValid (progValid),
    .outWord  (progWord),
    .outReady (progReady)
  );

  assign {progGenIdx, progPeriod, progTicks, progTag} = progWord;

endmodule

`default_nettype wire

//--- logic/cfgPkg.sv
`default_nettype none

`include "cfgDefs_defs.svh"

package cfgPkg;

  // one configuration register
  typedef logic [`CFG_NCONF-1:0] confWordT;

  // index into the register bank
  typedef logic [$clog2(`CFG_NREG)-1:0] regIdxT;

  // time in units
  typedef logic [`TM_TIME-1:0] timeT;

  // clocks per time unit
  typedef logic [`TM_UNIT-1:0] unitLenT;

  // packed spike generator program word
  typedef logic [`CFG_PROG_W-1:0] progWordT;

  // APB slave phases
  typedef enum logic {
    IDLE,
    ACCESS
  } apbStateT;

endpackage

`default_nettype wire

//--- logic/cfgTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "cfgDefs_defs.svh"

module cfgTop
  import cfgPkg::*;
(
  input  wire logic                    clk,
  input  wire logic                    rstN,
  // APB
  input  wire logic                    psel,
  input  wire logic                    penable,
  input  wire logic                    pwrite,
  input  wire logic [`CFG_ADDR_W-1:0]  paddr,
  input  wire confWordT                pwdata,
  output confWordT                     prdata,
  output logic                         pready,
  output logic                         pslverr,
  // block configuration
  output logic [`SF_FILTS-1:0]         filtsUsed,
  output logic [`SF_STATE-1:0]         incrementConstant,
  output logic [`SF_STATE-1:0]         decayConstant,
  output logic [`SG_GENS-1:0]          gensUsed,
  output logic [`SG_GENS-1:0]          gensEn,
  output logic                         reportTags,
  output logic                         pReset,
  output logic                         sReset,
  // generator program
  output logic                         progValid,
  input  wire logic                    progReady,
  output logic [`SG_GENS-1:0]          progGenIdx,
  output logic [`SG_PERIOD-1:0]        progPeriod,
  output logic [`SG_PERIOD-1:0]        progTicks,
  output logic [`SG_TAG-1:0]           progTag,
  // time
  output timeT                         currentTime,
  output logic                         unitTick,
  output logic                         hbPulse
);

  confWordT [`CFG_NREG-1:0] regBank;
  confWordT [`CFG_NREG-1:0] regResetVals;
  confWordT                 chunkData;
  logic                     chunkValid;
  logic                     chunkReady;
  unitLenT                  unitLen;
  timeT                     timeElapsed;
  timeT                     sendHbEvery;
  logic                     resetTime;

  cfgApbSlave u_slave (
    .clk          (clk),
    .rstN         (rstN),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .prdata       (prdata),
    .pready       (pready),
    .pslverr      (pslverr),
    .regResetVals (regResetVals),
    .regBank      (regBank),
    .chunkValid   (chunkValid),
    .chunkData    (chunkData),
    .chunkReady   (chunkReady)
  );

  cfgMapper u_mapper (
    .clk               (clk),
    .rstN              (rstN),
    .regBank           (regBank),
    .regResetVals      (regResetVals),
    .filtsUsed         (filtsUsed),
    .incrementConstant (incrementConstant),
    .decayConstant     (decayConstant),
    .gensUsed          (gensUsed),
    .gensEn            (gensEn),
    .unitLen           (unitLen),
    .timeElapsed       (timeElapsed),
    .sendHbEvery       (sendHbEvery),
    .resetTime         (resetTime),
    .reportTags        (reportTags),
    .pReset            (pReset),
    .sReset            (sReset),
    .chunkValid        (chunkValid),
    .chunkData         (chunkData),
    .chunkReady        (chunkReady),
    .progValid         (progValid),
    .progReady         (progReady),
    .progGenIdx        (progGenIdx),
    .progPeriod        (progPeriod),
    .progTicks         (progTicks),
    .progTag           (progTag)
  );

  timeMgr u_timeMgr (
    .clk         (clk),
    .rstN        (rstN),
    .unitLen     (unitLen),
    .timeElapsed (timeElapsed),
    .sendHbEvery (sendHbEvery),
    .resetTime   (resetTime),
    .currentTime (currentTime),
    .unitTick    (unitTick),
    .hbPulse     (hbPulse)
  );

endmodule

`default_nettype wire

//--- logic/progDeserializer.sv
`timescale 1ns/1ps
`default_nettype none

module progDeserializer
  import cfgPkg::*;
#(
  parameter int outW    = 47,
  parameter int nChunks = 3
) (
  input  wire logic              clk,
  input  wire logic              rstN,
  input  wire logic              inValid,
  input  wire confWordT          inData,
  output logic                   inReady,
  output logic                   outValid,
  output logic [outW-1:0]        outWord,
  input  wire logic              outReady
);

  localparam int InW  = $bits(confWordT);
  localparam int CntW = (nChunks > 1) ? $clog2(nChunks) : 1;
  localparam logic [CntW-1:0] LastCnt = CntW'(nChunks - 1);

  logic [CntW-1:0]         chunkCnt;
  logic [nChunks*InW-1:0]  shiftBuf;
  logic                    inXfer;

  // no new chunks while a finished word waits
  assign inReady = !outValid;
  assign inXfer  = inValid && inReady;

  // chunks enter at the top, the first one ends up in the low bits
  always_ff @(posedge clk) begin
    if (inXfer) begin
      shiftBuf <= {inData, shiftBuf[nChunks*InW-1:InW]};
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      chunkCnt <= '0;
      outValid <= 1'b0;
    end else begin
      if (inXfer) begin
        chunkCnt <= (chunkCnt == LastCnt) ? '0 : chunkCnt + 1'b1;
      end
      if (inXfer && (chunkCnt == LastCnt)) begin
        outValid <= 1'b1;
      end else if (outReady) begin
        outValid <= 1'b0;
      end
    end
  end

  assign outWord = shiftBuf[outW-1:0];

endmodule

`default_nettype wire

//--- logic/timeMgr.sv
`timescale 1ns/1ps
`default_nettype none

module timeMgr
  import cfgPkg::*;
(
  input  wire logic     clk,
  input  wire logic     rstN,
  input  wire unitLenT  unitLen,
  input  wire timeT     timeElapsed,
  input  wire timeT     sendHbEvery,
  input  wire logic     resetTime,
  output timeT          currentTime,
  output logic          unitTick,
  output logic          hbPulse
);

  unitLenT unitCnt;
  unitLenT unitLast;
  timeT    hbCnt;
  timeT    hbNext;
  logic    wrap;
  logic    hbDue;

  // zero length unit behaves as one clock
  assign unitLast = (unitLen == '0) ? '0 : unitLen - 1'b1;
  // >= so a shortened unit takes effect at once
  assign wrap     = unitCnt >= unitLast;

  // units since the last heartbeat, counting this tick
  assign hbNext = hbCnt + 1'b1;
  assign hbDue  = hbNext >= sendHbEvery;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      unitCnt     <= '0;
      hbCnt       <= '0;
      currentTime <= '0;
      unitTick    <= 1'b0;
      hbPulse     <= 1'b0;
    end else if (resetTime) begin
      // host owns the time while reload is held
      unitCnt     <= '0;
      hbCnt       <= '0;
      currentTime <= timeElapsed;
      unitTick    <= 1'b0;
      hbPulse     <= 1'b0;
    end else begin
      unitTick <= wrap;
      hbPulse  <= wrap && hbDue;
      if (wrap) begin
        unitCnt     <= '0;
        currentTime <= currentTime + 1'b1;
        hbCnt       <= hbDue ? '0 : hbNext;
      end else begin
        unitCnt <= unitCnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- project.f
+incdir+logic
logic/cfgPkg.sv
logic/cfgApbSlave.sv
logic/progDeserializer.sv
logic/cfgMapper.sv
logic/timeMgr.sv
logic/cfgTop.sv
tb/tbClock.sv
tb/cfgTopTb.sv

//--- tb/cfgTopTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cfgDefs_defs.svh"

module cfgTopTb
  import cfgPkg::*;
();

  // longest run is well under 2000 cycles
  localparam int MaxCycles = 20000;

  logic                       clk;
  logic                       rstN;
  logic                       psel;
  logic                       penable;
  logic                       pwrite;
  logic [`CFG_ADDR_W-1:0]     paddr;
  confWordT                   pwdata;
  confWordT                   prdata;
  logic                       pready;
  logic                       pslverr;
  logic [`SF_FILTS-1:0]       filtsUsed;
  logic [`SF_STATE-1:0]       incrementConstant;
  logic [`SF_STATE-1:0]       decayConstant;
  logic [`SG_GENS-1:0]        gensUsed;
  logic [`SG_GENS-1:0]        gensEn;
  logic                       reportTags;
  logic                       pReset;
  logic                       sReset;
  logic                       progValid;
  logic                       progReady;
  logic [`SG_GENS-1:0]        progGenIdx;
  logic [`SG_PERIOD-1:0]      progPeriod;
  logic [`SG_PERIOD-1:0]      progTicks;
  logic [`SG_TAG-1:0]         progTag;
  timeT                       currentTime;
  logic                       unitTick;
  logic                       hbPulse;
  logic [`CFG_PROG_W-1:0]     progSeen;

  // expected register contents
  confWordT model [`CFG_NREG];
  integer   seed = 32'hfbe3_3175;
  int       valueErrors = 0;
  int       protocolErrors = 0;
  int       cycleCnt;

  tbClock u_clk (
    .clk  (clk),
    .rstN (rstN)
  );

  cfgTop u_dut (
    .clk               (clk),
    .rstN              (rstN),
    .psel              (psel),
    .penable           (penable),
    .pwrite            (pwrite),
    .paddr             (paddr),
    .pwdata            (pwdata),
    .prdata            (prdata),
    .pready            (pready),
    .pslverr           (pslverr),
    .filtsUsed         (filtsUsed),
    .incrementConstant (incrementConstant),
    .decayConstant     (decayConstant),
    .gensUsed          (gensUsed),
    .gensEn            (gensEn),
    .reportTags        (reportTags),
    .pReset            (pReset),
    .sReset            (sReset),
    .progValid         (progValid),
    .progReady         (progReady),
    .progGenIdx        (progGenIdx),
    .progPeriod        (progPeriod),
    .progTicks         (progTicks),
    .progTag           (progTag),
    .currentTime       (currentTime),
    .unitTick          (unitTick),
    .hbPulse           (hbPulse)
  );

  assign progSeen = {progGenIdx, progPeriod, progTicks, progTag};

  ////////////////////////////////////////////////////////////////////////////
  // checkers
  ////////////////////////////////////////////////////////////////////////////

  task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      valueErrors++;
      $display("** Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic reportFailure(input string what);
    protocolErrors++;
    $display("** Error at %0t: %s", $time, what);
  endtask

  // held word must not move until the consumer takes it
  assert property (@(posedge clk) disable iff (!rstN)
    progValid && !progReady |=> progValid && $stable(progSeen))
    else reportFailure("program word changed or dropped before progReady");

  assert property (@(posedge clk) disable iff (!rstN) hbPulse |-> unitTick)
    else reportFailure("hbPulse without a unit tick");

  assert property (@(posedge clk) disable iff (!rstN) pready |-> psel && penable)
    else reportFailure("pready outside an access phase");

  assert property (@(posedge clk) disable iff (!rstN) pslverr |-> pready)
    else reportFailure("pslverr without pready");

  // register words low first and cut to the field width
  function automatic logic [63:0] wordsToField(input int firstIdx, input int nWords,
                                               input int width);
    logic [63:0] acc;
    acc = '0;
    for (int i = nWords - 1; i >= 0; i--) begin
      acc = (acc << 16) | 64'(model[firstIdx + i]);
    end
    return acc & ((64'd1 << width) - 64'd1);
  endfunction

  task automatic checkFields();
    // fields are stable by the falling edge
    @(negedge clk);
    checkValue("filtsUsed", 64'(filtsUsed), wordsToField(`CFG_REG_FILTS_USED, 1, `SF_FILTS));
    checkValue("incrementConstant", 64'(incrementConstant),
               wordsToField(`CFG_REG_INC_CONST, 2, `SF_STATE));
    checkValue("decayConstant", 64'(decayConstant),
               wordsToField(`CFG_REG_DECAY_CONST, 2, `SF_STATE));
    checkValue("gensUsed", 64'(gensUsed), wordsToField(`CFG_REG_GENS_USED, 1, `SG_GENS));
    checkValue("gensEn", 64'(gensEn), wordsToField(`CFG_REG_GENS_EN, 1, `SG_GENS));
    checkValue("unitLen", 64'(u_dut.unitLen), wordsToField(`CFG_REG_UNIT_LEN, 1, `TM_UNIT));
    checkValue("timeElapsed", 64'(u_dut.timeElapsed),
               wordsToField(`CFG_REG_TIME_ELAPSED, 3, `TM_TIME));
    checkValue("sendHbEvery", 64'(u_dut.sendHbEvery),
               wordsToField(`CFG_REG_HB_EVERY, 3, `TM_TIME));
    checkValue("resetTime", 64'(u_dut.resetTime), wordsToField(`CFG_REG_RESET_TIME, 1, 1));
    checkValue("reportTags", 64'(reportTags), wordsToField(`CFG_REG_REPORT_TAGS, 1, 1));
    checkValue("pReset", 64'(pReset), wordsToField(`CFG_REG_BD_RESET, 1, 1));
    checkValue("sReset", 64'(sReset), wordsToField(`CFG_REG_BD_RESET, 1, 2) >> 1);
  endtask

  // genIdx, period, ticks, tag from the top down
  task automatic checkProgWord(input logic [46:0] w);
    checkValue("progGenIdx", 64'(progGenIdx), 64'(w[46:43]));
    checkValue("progPeriod", 64'(progPeriod), 64'(w[42:27]));
    checkValue("progTicks", 64'(progTicks), 64'(w[26:11]));
    checkValue("progTag", 64'(progTag), 64'(w[10:0]));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // APB driver
  ////////////////////////////////////////////////////////////////////////////

  task automatic apbStart(input logic write, input logic [7:0] addr, input confWordT data);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
  endtask

  // sample on the falling edge and release after the completing edge
  task automatic apbFinish(output confWordT rdata, output logic err);
    @(negedge clk);
    while (!pready) @(negedge clk);
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apbWrite(input logic [7:0] addr, input confWordT data, output logic err);
    confWordT unused;
    apbStart(1'b1, addr, data);
    apbFinish(unused, err);
  endtask

  task automatic apbRead(input logic [7:0] addr, output confWordT data, output logic err);
    apbStart(1'b0, addr, '0);
    apbFinish(data, err);
  endtask

  task automatic writeReg(input int idx, input confWordT data);
    logic err;
    apbWrite(8'(idx * 4), data, err);
    checkValue($sformatf("pslverr write reg %0d", idx), 64'(err), 64'd0);
    model[idx] = data;
  endtask

  task automatic readExpect(input int idx);
    confWordT data;
    logic     err;
    apbRead(8'(idx * 4), data, err);
    checkValue($sformatf("prdata reg %0d", idx), 64'(data), 64'(model[idx]));
    checkValue($sformatf("pslverr read reg %0d", idx), 64'(err), 64'd0);
  endtask

  task automatic waitProgValid();
    @(negedge clk);
    while (!progValid) @(negedge clk);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin : watchdog
    cycleCnt = 0;
    while (cycleCnt < MaxCycles) begin
      @(posedge clk);
      cycleCnt++;
    end
    $display("timeout: run did not finish within %0d cycles", MaxCycles);
    $display("Simulation failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin : mainSeq
    confWordT    data;
    logic        err;
    logic [7:0]  addr;
    confWordT    chunk [6];
    logic [46:0] expWord;
    timeT        tElapsed;
    int          unitU;
    int          hbH;
    int          tickCnt;
    int          lastTick;
    int          cyc;

    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    progReady = 1'b0;
    for (int i = 0; i < `CFG_NREG; i++) begin
      model[i] = '0;
    end
    model[`CFG_REG_INC_CONST]   = 16'd1;
    model[`CFG_REG_UNIT_LEN]    = 16'd10000;
    model[`CFG_REG_HB_EVERY]    = 16'd10000;
    model[`CFG_REG_REPORT_TAGS] = 16'd1;
    model[`CFG_REG_BD_RESET]    = 16'd3;

    wait (rstN);
    @(posedge clk);

    // reset values
    for (int i = 0; i < `CFG_NREG; i++) readExpect(i);
    checkValue("pReset after reset", 64'(pReset), 64'd1);
    checkValue("sReset after reset", 64'(sReset), 64'd1);
    checkValue("reportTags after reset", 64'(reportTags), 64'd1);
    checkValue("unitLen after reset", 64'(u_dut.unitLen), 64'd10000);
    checkFields();

    // random words into the mapped registers
    for (int i = 0; i <= `CFG_REG_BD_RESET; i++) writeReg(i, confWordT'($random(seed)));
    for (int i = 0; i <= `CFG_REG_BD_RESET; i++) readExpect(i);
    checkFields();

    // reserved words and then out of range addresses
    for (int i = `CFG_REG_BD_RESET + 1; i < `CFG_NREG; i++) readExpect(i);
    for (int i = `CFG_REG_BD_RESET + 1; i < `CFG_NREG; i++) begin
      writeReg(i, confWordT'($random(seed)));
      readExpect(i);
    end
    repeat (6) begin
      addr = 8'h81 + 8'($unsigned($random(seed)) % 127);
      apbWrite(addr, confWordT'($random(seed)), err);
      checkValue($sformatf("pslverr write 0x%0h", addr), 64'(err), 64'd1);
      apbRead(addr, data, err);
      checkValue($sformatf("pslverr read 0x%0h", addr), 64'(err), 64'd1);
      checkValue($sformatf("prdata read 0x%0h", addr), 64'(data), 64'd0);
    end
    apbRead(`CFG_PROG_ADDR, data, err);
    checkValue("prdata program port", 64'(data), 64'd0);
    checkValue("pslverr program port", 64'(err), 64'd0);
    for (int i = 0; i < `CFG_NREG; i++) readExpect(i);

    ////////////////////////////////////////////////////////////////////////////
    // program words
    ////////////////////////////////////////////////////////////////////////////

    for (int i = 0; i < 6; i++) chunk[i] = confWordT'($random(seed));
    apbWrite(`CFG_PROG_ADDR, chunk[0], err);
    apbWrite(`CFG_PROG_ADDR, chunk[1], err);
    @(negedge clk);
    checkValue("progValid after two chunks", 64'(progValid), 64'd0);
    apbWrite(`CFG_PROG_ADDR, chunk[2], err);
    waitProgValid();
    expWord = {chunk[2][14:0], chunk[1], chunk[0]};
    checkProgWord(expWord);

    // fourth chunk must stall while the word is held
    apbStart(1'b1, `CFG_PROG_ADDR, chunk[3]);
    repeat (6) begin
      @(negedge clk);
      if (pready) reportFailure("program write completed while a word was pending");
      checkProgWord(expWord);
    end
    @(posedge clk);
    progReady <= 1'b1;
    apbFinish(data, err);
    checkValue("pslverr stalled program write", 64'(err), 64'd0);
    progReady <= 1'b0;

    apbWrite(`CFG_PROG_ADDR, chunk[4], err);
    apbWrite(`CFG_PROG_ADDR, chunk[5], err);
    waitProgValid();
    expWord = {chunk[5][14:0], chunk[4], chunk[3]};
    checkProgWord(expWord);
    @(posedge clk);
    progReady <= 1'b1;
    @(posedge clk);
    progReady <= 1'b0;
    @(negedge clk);
    checkValue("progValid after accept", 64'(progValid), 64'd0);

    ////////////////////////////////////////////////////////////////////////////
    // time manager
    ////////////////////////////////////////////////////////////////////////////

    tElapsed = timeT'({$random(seed), $random(seed)});
    unitU    = 2 + int'($unsigned($random(seed)) % 8);
    hbH      = 2 + int'($unsigned($random(seed)) % 4);

    writeReg(`CFG_REG_RESET_TIME, 16'd1);
    writeReg(`CFG_REG_TIME_ELAPSED, tElapsed[15:0]);
    writeReg(`CFG_REG_TIME_ELAPSED + 1, tElapsed[31:16]);
    writeReg(`CFG_REG_TIME_ELAPSED + 2, tElapsed[47:32]);
    @(posedge clk);
    repeat (8) begin
      @(negedge clk);
      checkValue("currentTime held", 64'(currentTime), 64'(tElapsed));
      checkValue("unitTick held", 64'(unitTick), 64'd0);
    end

    writeReg(`CFG_REG_UNIT_LEN, confWordT'(unitU));
    writeReg(`CFG_REG_HB_EVERY, confWordT'(hbH));
    writeReg(`CFG_REG_HB_EVERY + 1, 16'd0);
    writeReg(`CFG_REG_HB_EVERY + 2, 16'd0);
    checkFields();
    writeReg(`CFG_REG_RESET_TIME, 16'd0);

    tickCnt  = 0;
    lastTick = 0;
    cyc      = 0;
    while (tickCnt < 4 * hbH) begin
      @(negedge clk);
      cyc++;
      if (unitTick) begin
        tickCnt++;
        // first tick only sets the reference
        if (tickCnt > 1) checkValue("unitTick interval", 64'(cyc - lastTick), 64'(unitU));
        lastTick = cyc;
      end
      checkValue("currentTime", 64'(currentTime), 64'(timeT'(tElapsed + tickCnt)));
      checkValue("hbPulse", 64'(hbPulse), 64'(unitTick && (tickCnt % hbH == 0)));
    end

    $display("checks done: %0d value errors, %0d protocol errors",
             valueErrors, protocolErrors);
    if (valueErrors + protocolErrors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
  parameter int resetCycles = 16
) (
  output logic clk,
  output logic rstN
);

  // 10 ns period
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    rstN = 1'b0;
    repeat (resetCycles) @(posedge clk);
    rstN <= 1'b1;
  end

endmodule

`default_nettype wire
